// ==== design/pixelFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelFifo
(
	input  wire logic Clk50,
	input  wire logic rst,
	pixelIf.sink      snk,
	pixelIf.source    src
);
	import runnerPkg::*;

	pixelReqT           mem [0:FIFO_DEPTH-1];
	logic [FIFO_AW-1:0] wrPtr;
	logic [FIFO_AW-1:0] rdPtr;
	logic [FIFO_AW:0]   count;
	logic               push;
	logic               pop;
	pixelReqT           head;

	assign snk.ready = (count != (FIFO_AW + 1)'(FIFO_DEPTH));
	assign push = snk.valid && snk.ready;
	assign pop = src.valid && src.ready;

	// head entry is a storage register, so a write shows up a cycle later
	assign head = mem[rdPtr];
	assign src.valid = (count != '0);
	assign src.x = head.x;
	assign src.y = head.y;
	assign src.last = head.last;

	always_ff @(posedge Clk50)
	begin
		if (push)
			mem[wrPtr] <= '{x: snk.x, y: snk.y, last: snk.last};
	end

	always_ff @(posedge Clk50)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			// count only moves when one side is idle
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/pixelIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream of screen coordinates
interface pixelIf;
	import runnerPkg::*;

	logic  valid;
	logic  ready;
	coordT x;
	coordT y;
	logic  last;

	modport source
	(
		output valid,
		output x,
		output y,
		output last,
		input  ready
	);

	modport sink
	(
		input  valid,
		input  x,
		input  y,
		input  last,
		output ready
	);

endinterface

`default_nettype wire

// ==== design/runnerDraw.sv ====
`timescale 1ns/1ps
`default_nettype none

module runnerDraw
(
	input  wire logic                Clk50,
	input  wire logic                rst,
	input  wire logic                frameTick,
	input  wire runnerPkg::coordT    posX,
	input  wire runnerPkg::coordT    posY,
	input  wire logic                dead,
	input  wire runnerPkg::gameStateT gameState,
	input  wire logic [7:0]          eggCode,
	input  wire logic                outReady,
	pixelIf.sink                     snk,
	output logic                     outValid,
	output runnerPkg::coordT         outX,
	output runnerPkg::coordT         outY,
	output logic                     outLast,
	output logic                     runnerOn,
	output runnerPkg::addrT          address
);
	import runnerPkg::*;

	logic [FRAME_CNT_W-1:0] frameCount;
	logic runPhase3;
	logic altChar;
	logic take;
	logic inX;
	logic inY;
	addrT baseAddr;
	addrT distX;
	addrT distY;
	addrT nextAddr;

	// animation phase, starts on frame 3
	always_ff @(posedge Clk50)
	begin
		if (rst)
		begin
			frameCount <= FRAME_CNT_W'(1);
			runPhase3 <= 1'b1;
		end
		else if (frameTick)
		begin
			if (frameCount == FRAME_CNT_W'(FRAMES_PER_STEP))
			begin
				runPhase3 <= ~runPhase3;
				frameCount <= FRAME_CNT_W'(1);
			end
			else
				frameCount <= frameCount + 1'b1;
		end
	end

	assign altChar = (eggCode == EGG_ALT);

	// sprite image selection
	always_comb
	begin
		if (gameState == TITLE)
			baseAddr = BASE_RUN1;
		else if (gameState == OVER || dead)
			baseAddr = altChar ? BASE_ALTDIE : BASE_DIE;
		else if (altChar)
			baseAddr = runPhase3 ? BASE_ALT3 : BASE_ALT4;
		else
			baseAddr = runPhase3 ? BASE_RUN3 : BASE_RUN4;
	end

	// offsets wrap modulo 2^18, only used when the sprite covers the pixel
	assign distX = addrT'(snk.x) - addrT'(posX);
	assign distY = addrT'(snk.y) - addrT'(posY);
	assign nextAddr = baseAddr + distY * addrT'(SPRITE_W) + distX;

	// 11 bits so the right and bottom edges never wrap
	assign inX = (snk.x >= posX) && (11'(snk.x) < 11'(posX) + 11'(SPRITE_W));
	assign inY = (snk.y >= posY) && (11'(snk.y) < 11'(posY) + 11'(SPRITE_H));

	// stage is free when empty or draining this cycle
	assign snk.ready = !outValid || outReady;
	assign take = snk.valid && snk.ready;

	always_ff @(posedge Clk50)
	begin
		if (rst)
			outValid <= 1'b0;
		else if (snk.ready)
			outValid <= snk.valid;
	end

	always_ff @(posedge Clk50)
	begin
		if (take)
		begin
			outX <= snk.x;
			outY <= snk.y;
			outLast <= snk.last;
			runnerOn <= inX && inY;
			address <= nextAddr;
		end
	end

endmodule

`default_nettype wire

// ==== design/runnerPkg.sv ====
`default_nettype none

package runnerPkg;

	// screen coordinate and sprite ROM word address
	typedef logic [9:0] coordT;
	typedef logic [17:0] addrT;

	typedef enum logic [1:0]
	{
		TITLE   = 2'd0,
		PLAYING = 2'd1,
		OVER    = 2'd2
	} gameStateT;

	// one queued pixel request, last marks the end of a window
	typedef struct packed
	{
		coordT x;
		coordT y;
		logic  last;
	} pixelReqT;

	// runner sprite geometry
	localparam int SPRITE_W = 88;
	localparam int SPRITE_H = 94;

	// animation toggles once every this many frame ticks
	localparam int FRAMES_PER_STEP = 10;
	localparam int FRAME_CNT_W = $clog2(FRAMES_PER_STEP + 1);

	// coordinate buffer between writer and drawer
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// sprite image start addresses in the ROM
	localparam addrT BASE_RUN1 = 18'd191323;
	localparam addrT BASE_RUN3 = 18'd207867;
	localparam addrT BASE_RUN4 = 18'd216139;
	localparam addrT BASE_DIE = 18'd46904;

	// alternate character images
	localparam addrT BASE_ALT3 = 18'd233303;
	localparam addrT BASE_ALT4 = 18'd241575;
	localparam addrT BASE_ALTDIE = 18'd249847;

	// easter-egg code for the alternate character
	localparam logic [7:0] EGG_ALT = 8'd1;

endpackage

`default_nettype wire

// ==== design/runnerSprite.sv ====
`timescale 1ns/1ps
`default_nettype none

module runnerSprite
(
	input  wire logic                 Clk50,
	input  wire logic                 rst,
	input  wire logic                 scanStart,
	input  wire runnerPkg::coordT     winX,
	input  wire runnerPkg::coordT     winY,
	input  wire runnerPkg::coordT     winW,
	input  wire runnerPkg::coordT     winH,
	output logic                      scanBusy,
	input  wire logic                 frameTick,
	input  wire runnerPkg::coordT     posX,
	input  wire runnerPkg::coordT     posY,
	input  wire logic                 dead,
	input  wire runnerPkg::gameStateT gameState,
	input  wire logic [7:0]           eggCode,
	input  wire logic                 outReady,
	output logic                      outValid,
	output runnerPkg::coordT          outX,
	output runnerPkg::coordT          outY,
	output logic                      outLast,
	output logic                      runnerOn,
	output runnerPkg::addrT           address
);

	// writer to buffer, buffer to drawer
	pixelIf scanToFifo ();
	pixelIf fifoToDraw ();

	scanWriter writer0
	(
		.Clk50     (Clk50),
		.rst       (rst),
		.scanStart (scanStart),
		.winX      (winX),
		.winY      (winY),
		.winW      (winW),
		.winH      (winH),
		.scanBusy  (scanBusy),
		.src       (scanToFifo.source)
	);

	pixelFifo fifo0
	(
		.Clk50 (Clk50),
		.rst   (rst),
		.snk   (scanToFifo.sink),
		.src   (fifoToDraw.source)
	);

	runnerDraw draw0
	(
		.Clk50     (Clk50),
		.rst       (rst),
		.frameTick (frameTick),
		.posX      (posX),
		.posY      (posY),
		.dead      (dead),
		.gameState (gameState),
		.eggCode   (eggCode),
		.outReady  (outReady),
		.snk       (fifoToDraw.sink),
		.outValid  (outValid),
		.outX      (outX),
		.outY      (outY),
		.outLast   (outLast),
		.runnerOn  (runnerOn),
		.address   (address)
	);

endmodule

`default_nettype wire

// ==== design/scanWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanWriter
(
	input  wire logic           Clk50,
	input  wire logic           rst,
	input  wire logic           scanStart,
	input  wire runnerPkg::coordT winX,
	input  wire runnerPkg::coordT winY,
	input  wire runnerPkg::coordT winW,
	input  wire runnerPkg::coordT winH,
	output logic                scanBusy,
	pixelIf.source              src
);
	import runnerPkg::*;

	logic  busy;
	logic  startScan;
	logic  xfer;
	logic  isLast;
	coordT startX;
	coordT lastCol;
	coordT lastRow;
	coordT colX;
	coordT rowY;

	// empty windows produce nothing, so they never start a scan
	assign startScan = scanStart && !busy && (winW != '0) && (winH != '0);
	assign xfer = busy && src.ready;
	assign isLast = (colX == lastCol) && (rowY == lastRow);

	assign scanBusy = busy;
	assign src.valid = busy;
	assign src.x = colX;
	assign src.y = rowY;
	assign src.last = isLast;

	always_ff @(posedge Clk50)
	begin
		if (rst)
			busy <= 1'b0;
		else if (startScan)
			busy <= 1'b1;
		else if (xfer && isLast)
			busy <= 1'b0;
	end

	// window capture and raster stepping
	always_ff @(posedge Clk50)
	begin
		if (startScan)
		begin
			startX <= winX;
			lastCol <= winX + winW - 10'd1;
			lastRow <= winY + winH - 10'd1;
			colX <= winX;
			rowY <= winY;
		end
		else if (xfer)
		begin
			if (colX == lastCol)
			begin
				// wrap to the next row
				colX <= startX;
				rowY <= rowY + 10'd1;
			end
			else
				colX <= colX + 10'd1;
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module runnerSpriteTb -f src.f -o simRunner

./obj_dir/simRunner | tee sim.log

if grep -q "sim failed" sim.log
then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== src.f ====
design/runnerPkg.sv
design/pixelIf.sv
design/scanWriter.sv
design/pixelFifo.sv
design/runnerDraw.sv
design/runnerSprite.sv
tests/tbClock.sv
tests/runnerSprite_assertions.sv
tests/runnerSpriteTb.sv

// ==== tests/runnerSpriteTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module runnerSpriteTb;
	import runnerPkg::*;

	// expected result of one drawn coordinate
	typedef struct packed
	{
		coordT x;
		coordT y;
		logic  last;
		logic  on;
		addrT  addr;
	} expItemT;

	localparam int NUM_SCANS = 15;
	localparam int MAX_W = 20;
	localparam int MAX_H = 12;
	localparam int TIMEOUT_CYCLES = 4 * NUM_SCANS * MAX_W * MAX_H + 1000;

	logic        Clk50, rst, scanStart, scanBusy, frameTick, dead;
	logic        outValid, outLast, runnerOn;
	logic        outReady = 1'b1;
	coordT       winX, winY, winW, winH, posX, posY, outX, outY;
	gameStateT   gameState;
	logic [7:0]  eggCode;
	addrT        address;
	logic [31:0] rngState, readyState;
	logic        randReady, mPhase3;
	logic        lastSeen;
	expItemT     expQ [$];
	int          errors = 0, rcvCount = 0, cycles = 0, testsPassed = 0, testsFailed = 0;
	int          mCount;

	tbClock clk0 (.clk(Clk50));
	runnerSprite dut0 (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		return r ^ (r << 5);
	endfunction

	function automatic int randRange(input int lo, input int hi);
		rngState = xorshift(rngState);
		return lo + int'(rngState % (hi - lo + 1));
	endfunction

	// image choice by state, dead flag, egg code and counted phase
	function automatic addrT expectedBase();
		logic alt;
		alt = (eggCode == EGG_ALT);
		case (1'b1)
			gameState == TITLE: return BASE_RUN1;
			gameState == OVER || dead: return alt ? BASE_ALTDIE : BASE_DIE;
			alt: return mPhase3 ? BASE_ALT3 : BASE_ALT4;
			default: return mPhase3 ? BASE_RUN3 : BASE_RUN4;
		endcase
	endfunction

	task automatic checkCoord(input string name, input coordT got, input coordT exp);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input addrT got, input addrT exp);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input bit got, input bit exp);
		if (got != exp)
		begin
			errors++;
			$display("Mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic step();
		@(posedge Clk50);
		#1;
	endtask

	// raster-order expectations for one window
	task automatic runScan(input int x0, input int y0, input int w, input int h);
		expItemT e;
		addrT base;
		int dx, dy;
		base = expectedBase();
		for (int r = 0; r < h; r++)
		begin
			for (int c = 0; c < w; c++)
			begin
				dx = x0 + c - int'(posX);
				dy = y0 + r - int'(posY);
				e.x = coordT'(x0 + c);
				e.y = coordT'(y0 + r);
				e.last = (r == h - 1) && (c == w - 1);
				e.on = (dx >= 0) && (dx < SPRITE_W) && (dy >= 0) && (dy < SPRITE_H);
				e.addr = addrT'(int'(base) + dy * SPRITE_W + dx);
				expQ.push_back(e);
			end
		end
		rcvCount = 0;
		lastSeen = 1'b0;
		winX = coordT'(x0);
		winY = coordT'(y0);
		winW = coordT'(w);
		winH = coordT'(h);
		scanStart = 1'b1;
		step();
		scanStart = 1'b0;
		// the window ends with the item the DUT flags as last
		while (!lastSeen)
			@(posedge Clk50);
		#1;
		if (rcvCount != w * h)
		begin
			errors++;
			$display("Mismatch itemCount got %h expected %h", rcvCount, w * h);
		end
		expQ.delete();
	endtask

	// window of random size somewhere around the sprite
	task automatic scanRandom(input int minW);
		int w, h;
		w = randRange(minW, MAX_W);
		h = randRange(3, MAX_H);
		runScan(int'(posX) - MAX_W / 2 + randRange(0, SPRITE_W),
			int'(posY) - MAX_H / 2 + randRange(0, SPRITE_H), w, h);
	endtask

	task automatic tickFrames(input int n);
		for (int i = 0; i < n; i++)
		begin
			frameTick = 1'b1;
			if (mCount == FRAMES_PER_STEP)
			begin
				mPhase3 = !mPhase3;
				mCount = 1;
			end
			else
				mCount++;
			step();
		end
		frameTick = 1'b0;
		step();
	endtask

	task automatic endTest(input string name, input int errBefore);
		if (errors == errBefore)
		begin
			testsPassed++;
			$display("test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - errBefore);
		end
	endtask

	// sample at the falling edge where outputs are stable before the transfer
	always @(negedge Clk50)
	begin : monitor
		expItemT e;
		if (!rst && outValid && outReady)
		begin
			rcvCount++;
			if (outLast)
				lastSeen = 1'b1;
			if (expQ.size() == 0)
			begin
				errors++;
				$display("output item at x %h y %h arrived with nothing expected", outX, outY);
			end
			else
			begin
				e = expQ.pop_front();
				checkCoord("outX", outX, e.x);
				checkCoord("outY", outY, e.y);
				checkFlag("outLast", outLast, e.last);
				checkFlag("runnerOn", runnerOn, e.on);
				if (e.on)
					checkAddr("address", address, e.addr);
			end
		end
	end

	always @(posedge Clk50)
	begin
		#1;
		readyState = xorshift(readyState);
		outReady = randReady ? (readyState[2:0] > 3'd2) : 1'b1;
	end

	always @(posedge Clk50)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the scans never finished", cycles);
			$display("sim failed");
			$finish;
		end
	end

	initial
	begin
		int errBefore;
		rngState = 32'h57f733cf;
		readyState = ~32'h57f733cf;
		{rst, scanStart, frameTick, dead, randReady} = 5'b10000;
		{winX, winY, winW, winH, posX, posY} = '0;
		gameState = TITLE;
		eggCode = 8'd0;
		lastSeen = 1'b0;
		mCount = 1;
		mPhase3 = 1'b1;
		repeat (4) @(posedge Clk50);
		#1;
		rst = 1'b0;

		errBefore = errors;
		checkFlag("scanBusy", scanBusy, 1'b0);
		checkFlag("outValid", outValid, 1'b0);
		endTest("reset", errBefore);

		// top-left and bottom-right sprite corners, then a random window
		errBefore = errors;
		posX = coordT'(randRange(100, 500));
		posY = coordT'(randRange(50, 300));
		runScan(int'(posX) - 4, int'(posY) - 3, 10, 6);
		runScan(int'(posX) + SPRITE_W - 5, int'(posY) + SPRITE_H - 4, 9, 7);
		scanRandom(4);
		endTest("title", errBefore);

		errBefore = errors;
		gameState = PLAYING;
		repeat (4)
		begin
			tickFrames(randRange(1, 25));
			scanRandom(4);
		end
		endTest("animation", errBefore);

		errBefore = errors;
		dead = 1'b1;
		scanRandom(4);
		dead = 1'b0;
		gameState = OVER;
		scanRandom(4);
		eggCode = EGG_ALT;
		scanRandom(4);
		gameState = PLAYING;
		scanRandom(4);
		// a full step flips to the other alternate image
		tickFrames(FRAMES_PER_STEP);
		scanRandom(4);
		endTest("images", errBefore);

		errBefore = errors;
		randReady = 1'b1;
		repeat (3)
		begin
			posX = coordT'(randRange(100, 500));
			posY = coordT'(randRange(50, 300));
			scanRandom(FIFO_DEPTH + 1);
		end
		endTest("backpressure", errBefore);

		$display("tests passed %0d failed %0d, errors %0d", testsPassed, testsFailed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/runnerSprite_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module runnerSprite_assertions
(
	input wire logic             Clk50,
	input wire logic             rst,
	input wire logic             scanStart,
	input wire logic             scanBusy,
	input wire logic             outValid,
	input wire logic             outReady,
	input wire runnerPkg::coordT outX,
	input wire runnerPkg::coordT outY,
	input wire logic             outLast,
	input wire logic             runnerOn,
	input wire runnerPkg::addrT  address
);

	// a stalled output item stays put until it is taken
	holdWhileStalled: assert property (@(posedge Clk50) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outX) && $stable(outY)
			&& $stable(outLast) && $stable(runnerOn) && $stable(address))
		else $error("output stage changed while stalled");

	resetClearsValid: assert property (@(posedge Clk50) rst |=> !outValid)
		else $error("outValid high during reset");

	// scans only begin on request
	busyNeedsStart: assert property (@(posedge Clk50) disable iff (rst)
		$rose(scanBusy) |-> $past(scanStart))
		else $error("scanBusy rose without scanStart");

endmodule

bind runnerSprite runnerSprite_assertions assert0 (.*);

`default_nettype wire

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock, 4 ns period
module tbClock
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

endmodule

`default_nettype wire
